// File: rtl/ks10Pkg.sv
/*
 * KS10 datapath types
 * Word and half-word types, the VMA layout and ramfile sizing
 */

`default_nettype none

package ks10Pkg;

   // Full data word, bit 0 is the MSB
   typedef logic [0:35] ks10Word;

   // Half word, left or right half of a ks10Word
   typedef logic [0:17] ks10Half;

   ////////////////////////////////////////////////////////////
   // VMA layout
   ////////////////////////////////////////////////////////////

   // Cycle flags, VMA bits 0 to 13
   typedef struct packed
   {
      logic user;           // Bit 0
      logic exec;
      logic fetch;
      logic readCycle;      // Bit 3
      logic wrTestCycle;
      logic writeCycle;
      logic extended;
      logic cacheInhibit;
      logic physical;       // Bit 8
      logic previous;
      logic ioCycle;
      logic wruCycle;
      logic vectCycle;
      logic ioByteCycle;    // Bit 13
   } vmaFlagsT;

   // Address, VMA bits 14 to 35
   typedef logic [14:35] vmaAddrT;

   typedef struct packed
   {
      vmaFlagsT flags;
      vmaAddrT  addr;
   } vmaFieldsT;

   // Loaded as a raw word, decoded as flags and address
   typedef union packed
   {
      ks10Word   raw;
      vmaFieldsT fields;
   } vmaWordU;

   ////////////////////////////////////////////////////////////
   // Ramfile sizing
   ////////////////////////////////////////////////////////////

   // ACs at 0 to 15, workspace above
   localparam int ramfileDepth = 64;

   typedef logic [0:$clog2(ramfileDepth)-1] ramAddrT;

endpackage

`default_nettype wire

// File: rtl/cromPkg.sv
/*
 * Control ROM microword
 * Field layout and the select encodings it carries
 */

`default_nettype none

package cromPkg;

   ////////////////////////////////////////////////////////////
   // Select encodings
   ////////////////////////////////////////////////////////////

   // DBUS source
   typedef enum logic [1:0]
   {
      dbusFlags   = 2'd0,
      dbusDp      = 2'd1,
      dbusRamfile = 2'd2,
      dbusDbm     = 2'd3
   } dbusSelE;

   // Data-bus mux source
   typedef enum logic [1:0]
   {
      dbmMem    = 2'd0,
      dbmVma    = 2'd1,
      dbmDpSwap = 2'd2,
      dbmNum    = 2'd3
   } dbmSelE;

   // Ramfile address source, code 3 unused
   typedef enum logic [1:0]
   {
      ramAc  = 2'd0,
      ramVma = 2'd1,
      ramNum = 2'd2
   } ramSelE;

   ////////////////////////////////////////////////////////////
   // Microword
   ////////////////////////////////////////////////////////////

   typedef struct packed
   {
      dbusSelE     dbusSel;
      dbmSelE      dbmSel;
      ramSelE      ramSel;
      logic [0:3]  acNum;       // Current AC
      logic [0:17] number;      // Magic number field
      logic        loadVma;     // Strobes
      logic        loadFlags;
      logic        ramWrite;
   } cromT;

endpackage

`default_nettype wire

// File: rtl/dbm.sv
/*
 * Data-bus mux
 * Selects memory data, the VMA, swapped datapath or the number field
 */

`timescale 1ns/1ps
`default_nettype none

module dbm
   import ks10Pkg::*, cromPkg::*;
(
   input  wire cromT    crom,       // Microword
   input  wire ks10Word memData,    // Memory read data
   input  wire vmaWordU vma,        // VMA register
   input  wire ks10Word dp,         // Datapath
   output ks10Word      dbmOut      // To DBUS mux
);

   ks10Word dpSwap;
   ks10Word numWord;

   // Halves exchanged
   assign dpSwap = {dp[18:35], dp[0:17]};

   // Number right-justified
   // left half zero
   assign numWord = {18'b0, crom.number};

   ////////////////////////////////////////////////////////////
   // Four-way select
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (crom.dbmSel)
         dbmMem:
            dbmOut = memData;
         // Whole VMA word, flags included
         dbmVma:
            dbmOut = vma.raw;
         dbmDpSwap:
            dbmOut = dpSwap;
         dbmNum:
            dbmOut = numWord;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/dbus.sv
/*
 * DBUS multiplexer
 * Picks flags, datapath, ramfile or DBM onto the DBUS; AC references
 * and cache hits on a read cycle take the ramfile in place of the DBM
 */

`timescale 1ns/1ps
`default_nettype none

module dbus
   import ks10Pkg::*, cromPkg::*;
(
   input  wire cromT    crom,       // Microword
   input  wire          cacheHit,   // Cache hit
   input  wire vmaWordU vma,        // VMA flags and address
   input  wire ks10Half flags,      // PC flags
   input  wire ks10Word dp,         // Datapath
   input  wire ks10Word ramOut,     // Ramfile read data
   input  wire ks10Word dbmOut,     // Data-bus mux
   output ks10Word      dbusOut     // DBUS
);

   logic readCycle;
   logic physical;
   logic acRef;
   logic forceRamfile;

   // VMA flags of interest
   assign readCycle = vma.fields.flags.readCycle;
   assign physical  = vma.fields.flags.physical;

   // AC reference
   // lowest 16 locations, never a physical reference
   assign acRef = ~physical & (vma.fields.addr[18:31] == '0);

   // Read from the ramfile instead of memory
   assign forceRamfile = (acRef | cacheHit) & readCycle;

   ////////////////////////////////////////////////////////////
   // Source select
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (crom.dbusSel)
         // Flags in left half, right half zero
         dbusFlags:
            dbusOut = {flags, 18'b0};
         dbusDp:
            dbusOut = dp;
         dbusRamfile:
            dbusOut = ramOut;
         // DBM unless overridden
         dbusDbm:
            dbusOut = forceRamfile ? ramOut : dbmOut;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/vmaRegister.sv
/*
 * Virtual memory address register
 * Flags and address loaded as one word from the datapath
 */

`timescale 1ns/1ps
`default_nettype none

module vmaRegister
   import ks10Pkg::*, cromPkg::*;
(
   input  wire          clk,        // Clock
   input  wire          reset,      // Synchronous reset
   input  wire cromT    crom,       // Microword
   input  wire ks10Word dp,         // Datapath
   output vmaWordU      vma         // VMA word
);

   ////////////////////////////////////////////////////////////
   // VMA register
   ////////////////////////////////////////////////////////////

   // Loaded raw from dp
   // flags in bits 0 to 13, address in 14 to 35
   //
   // Sits next to the DBUS mux, where its
   // flags and address decide the ramfile override
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vma <= '0;
      end
      else if (crom.loadVma)
      begin
         vma.raw <= dp;
      end
   end

   // Readers
   //   dbus    - fields.flags and fields.addr
   //   ramfile - fields.addr[30:35]
   //   dbm     - raw

endmodule

`default_nettype wire

// File: rtl/ramfile.sv
/*
 * Ramfile
 * AC and workspace store; synchronous write, asynchronous read
 */

`timescale 1ns/1ps
`default_nettype none

module ramfile
   import ks10Pkg::*, cromPkg::*;
(
   input  wire          clk,        // Clock
   input  wire cromT    crom,       // Microword
   input  wire vmaWordU vma,        // VMA register
   input  wire ks10Word dbusIn,     // Write data from DBUS
   output ks10Word      ramOut      // Read data
);

   // Word store
   ks10Word mem [0:ramfileDepth-1];

   ramAddrT ramAddr;

   ////////////////////////////////////////////////////////////
   // Address select
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (crom.ramSel)
         // Current AC, zero-extended
         ramAc:
            ramAddr = {2'b00, crom.acNum};
         // Low VMA bits
         ramVma:
            ramAddr = vma.fields.addr[30:35];
         ramNum:
            ramAddr = crom.number[12:17];
         // Unused code
         default:
            ramAddr = {2'b00, crom.acNum};
      endcase
   end

   // Write port
   always_ff @(posedge clk)
   begin
      if (crom.ramWrite)
      begin
         mem[ramAddr] <= dbusIn;
      end
   end

   // Read port, new data visible next cycle
   assign ramOut = mem[ramAddr];

endmodule

`default_nettype wire

// File: rtl/pcFlags.sv
/*
 * PC flags register
 * 18 processor flags loaded from the DBUS left half
 */

`timescale 1ns/1ps
`default_nettype none

module pcFlags
   import ks10Pkg::*, cromPkg::*;
(
   input  wire          clk,        // Clock
   input  wire          reset,      // Synchronous reset
   input  wire cromT    crom,       // Microword
   input  wire ks10Word dbusIn,     // DBUS
   output ks10Half      flags       // Processor flags
);

   ////////////////////////////////////////////////////////////
   // Flags register
   ////////////////////////////////////////////////////////////

   // Left half of DBUS only
   // right half ignored
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         flags <= '0;
      end
      else if (crom.loadFlags)
      begin
         flags <= dbusIn[0:17];
      end
   end

endmodule

`default_nettype wire

// File: rtl/dataBus.sv
/*
 * Data bus slice
 * DBUS and DBM muxes with the VMA, PC flags and ramfile around them
 */

`timescale 1ns/1ps
`default_nettype none

module dataBus
   import ks10Pkg::*, cromPkg::*;
(
   input  wire          clk,        // Clock
   input  wire          reset,      // Synchronous reset
   input  wire cromT    crom,       // Microword
   input  wire ks10Word dp,         // Datapath
   input  wire ks10Word memData,    // Memory read data
   input  wire          cacheHit,   // Cache hit
   output ks10Word      dbus,       // DBUS
   output vmaWordU      vma,        // VMA register
   output ks10Half      flags       // PC flags
);

   // Internal buses
   ks10Word dbmOut;
   ks10Word ramOut;

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////

   vmaRegister uVmaRegister
   (
      .clk     (clk),
      .reset   (reset),
      .crom    (crom),
      .dp      (dp),
      .vma     (vma)
   );

   // Loaded from the DBUS
   pcFlags uPcFlags
   (
      .clk     (clk),
      .reset   (reset),
      .crom    (crom),
      .dbusIn  (dbus),
      .flags   (flags)
   );

   // Written from the DBUS
   ramfile uRamfile
   (
      .clk     (clk),
      .crom    (crom),
      .vma     (vma),
      .dbusIn  (dbus),
      .ramOut  (ramOut)
   );

   ////////////////////////////////////////////////////////////
   // Muxes
   ////////////////////////////////////////////////////////////

   dbm uDbm
   (
      .crom    (crom),
      .memData (memData),
      .vma     (vma),
      .dp      (dp),
      .dbmOut  (dbmOut)
   );

   dbus uDbus
   (
      .crom     (crom),
      .cacheHit (cacheHit),
      .vma      (vma),
      .flags    (flags),
      .dp       (dp),
      .ramOut   (ramOut),
      .dbmOut   (dbmOut),
      .dbusOut  (dbus)
   );

endmodule

`default_nettype wire

// File: dv/dataBusTb.sv
/*
 * Data bus testbench
 * Directed tests of the DBUS sources, ramfile, VMA, flags and override
 */

`timescale 1ns/1ps
`default_nettype none

module dataBusTb
   import ks10Pkg::*, cromPkg::*;
();

   localparam int          clkPeriod   = 40;
   localparam int          resetCycles = 16;
   localparam int          stepLimit   = 64;
   localparam int          runLimit    = 4000;
   localparam logic [31:0] lfsrSeed    = 32'hb72bf771;
   localparam logic [31:0] lfsrTaps    = 32'h80200003;

   logic    clk = 1'b0;
   logic    reset;
   cromT    crom;
   ks10Word dp;
   ks10Word memData;
   logic    cacheHit;
   ks10Word dbus;
   vmaWordU vma;
   ks10Half flags;

   int          errors;
   int          checks;
   logic [31:0] lfsr;

   // Expected ramfile contents
   ks10Word model [0:ramfileDepth-1];

   dataBus UUT
   (
      .clk      (clk),
      .reset    (reset),
      .crom     (crom),
      .dp       (dp),
      .memData  (memData),
      .cacheHit (cacheHit),
      .dbus     (dbus),
      .vma      (vma),
      .flags    (flags)
   );

   initial
   begin
      forever #(clkPeriod / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // Galois LFSR stepped once per bit
   function automatic logic takeBit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
      begin
         lfsr = lfsr ^ lfsrTaps;
      end
      return b;
   endfunction

   function automatic ks10Word randWord();
      ks10Word w;
      w = '0;
      for (int i = 0; i < 36; i++)
      begin
         w = {w[1:35], takeBit()};
      end
      return w;
   endfunction

   task automatic checkEq(input ks10Word actual, input ks10Word expected, input string msg);
      checks++;
      if (actual !== expected)
      begin
         $display("mismatch at %0t: %s, got %h expected %h", $time, msg, actual, expected);
         errors++;
      end
   endtask

   // Falling edges only
   task automatic stepCycles(input int n);
      int waited;
      waited = 0;
      while (waited < n && waited < stepLimit)
      begin
         @(negedge clk);
         waited++;
      end
      if (waited < n)
      begin
         $display("wait of %0d cycles is longer than the %0d cycle limit", n, stepLimit);
         errors++;
      end
   endtask

   // Quiet microword with no strobes
   task automatic idle();
      crom = '0;
      cacheHit = 1'b0;
   endtask

   task automatic loadVmaWord(input ks10Word w);
      idle();
      crom.loadVma = 1'b1;
      dp = w;
      stepCycles(1);
      crom.loadVma = 1'b0;
      checkEq(vma.raw, w, "vma load");
   endtask

   // DBUS carries dp during the write
   task automatic writeRam(input ramSelE sel, input int addr, input ks10Word data);
      ks10Word r;
      r = randWord();
      idle();
      crom.dbusSel = dbusDp;
      crom.ramSel = sel;
      crom.acNum = addr[3:0];
      // Upper number bits are not part of the address
      crom.number = {r[0:11], addr[5:0]};
      crom.ramWrite = 1'b1;
      dp = data;
      stepCycles(1);
      crom.ramWrite = 1'b0;
      model[addr] = data;
   endtask

   task automatic readRam(input ramSelE sel, input int addr);
      idle();
      crom.dbusSel = dbusRamfile;
      crom.ramSel = sel;
      crom.acNum = addr[3:0];
      crom.number = {12'b0, addr[5:0]};
      stepCycles(1);
      checkEq(dbus, model[addr], $sformatf("ramfile word %0d, select %0d", addr, sel));
   endtask

   // DBM memory source with or without the ramfile override
   task automatic checkMemRead(input logic hit, input logic fromRam, input int addr,
                               input string msg);
      ks10Word m;
      m = randWord();
      idle();
      crom.dbusSel = dbusDbm;
      crom.dbmSel = dbmMem;
      crom.ramSel = ramVma;
      cacheHit = hit;
      memData = m;
      stepCycles(1);
      checkEq(dbus, fromRam ? model[addr] : m, msg);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic testReset();
      idle();
      crom.dbusSel = dbusFlags;
      stepCycles(1);
      checkEq(dbus, '0, "flags after reset");
      checkEq({18'b0, flags}, '0, "flags register after reset");
      crom.dbusSel = dbusDbm;
      crom.dbmSel = dbmVma;
      stepCycles(1);
      checkEq(dbus, '0, "vma after reset");
   endtask

   task automatic testSources();
      ks10Word d;
      ks10Word n;
      for (int i = 0; i < 4; i++)
      begin
         d = randWord();
         n = randWord();
         idle();
         dp = d;
         crom.dbusSel = dbusDp;
         stepCycles(1);
         checkEq(dbus, d, "dp source");
         crom.dbusSel = dbusDbm;
         crom.dbmSel = dbmDpSwap;
         stepCycles(1);
         checkEq(dbus, {d[18:35], d[0:17]}, "swapped dp");
         crom.dbmSel = dbmNum;
         crom.number = n[18:35];
         stepCycles(1);
         checkEq(dbus, {18'b0, n[18:35]}, "number field");
         // VMA is still clear so no read cycle
         checkMemRead(1'b0, 1'b0, 0, "memory data");
      end
   endtask

   task automatic testRamfile();
      // All ACs then a spread of workspace words
      for (int a = 0; a < 16; a++)
      begin
         writeRam(ramAc, a, randWord());
      end
      for (int k = 0; k < 8; k++)
      begin
         writeRam(ramNum, 16 + k * 6, randWord());
      end
      for (int a = 0; a < 16; a++)
      begin
         readRam(ramAc, a);
         readRam(ramNum, a);
      end
      for (int k = 0; k < 8; k++)
      begin
         readRam(ramNum, 16 + k * 6);
      end
   endtask

   task automatic testVmaFlags();
      ks10Word w;
      ks10Word d;
      w = randWord();
      // Not a read cycle so no override
      w[3] = 1'b0;
      loadVmaWord(w);
      crom.dbusSel = dbusDbm;
      crom.dbmSel = dbmVma;
      stepCycles(1);
      checkEq(dbus, w, "vma through dbm");
      d = randWord();
      idle();
      crom.dbusSel = dbusDp;
      crom.loadFlags = 1'b1;
      dp = d;
      stepCycles(1);
      idle();
      crom.dbusSel = dbusFlags;
      stepCycles(1);
      checkEq({18'b0, flags}, {18'b0, d[0:17]}, "flags register");
      checkEq(dbus, {d[0:17], 18'b0}, "flags from dbus left half");
   endtask

   task automatic testOverride();
      ks10Word acVma;
      ks10Word highVma;
      ks10Word v;
      // Read cycle at AC 7 and at workspace 45
      acVma = '0;
      acVma[3] = 1'b1;
      acVma[32:35] = 4'd7;
      highVma = '0;
      highVma[3] = 1'b1;
      highVma[30:35] = 6'd45;
      loadVmaWord(acVma);
      writeRam(ramVma, 7, randWord());
      checkMemRead(1'b0, 1'b1, 7, "AC reference takes ramfile");
      v = acVma;
      v[8] = 1'b1;
      loadVmaWord(v);
      checkMemRead(1'b0, 1'b0, 7, "physical reference takes memory");
      loadVmaWord(highVma);
      writeRam(ramVma, 45, randWord());
      checkMemRead(1'b0, 1'b0, 45, "cache miss takes memory");
      checkMemRead(1'b1, 1'b1, 45, "cache hit takes ramfile");
      // No read cycle so never overridden
      for (int i = 0; i < 4; i++)
      begin
         v = (i < 2) ? acVma : highVma;
         v[3] = 1'b0;
         loadVmaWord(v);
         checkMemRead(i[0], 1'b0, 0, $sformatf("no read cycle, case %0d", i));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      errors = 0;
      checks = 0;
      lfsr = lfsrSeed;
      reset = 1'b1;
      crom = '0;
      dp = '0;
      memData = '0;
      cacheHit = 1'b0;
      stepCycles(resetCycles);
      reset = 1'b0;
      testReset();
      testSources();
      testRamfile();
      testVmaFlags();
      testOverride();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Run watchdog
   initial
   begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < runLimit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, the tests did not finish within %0d cycles", runLimit);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
rtl/ks10Pkg.sv
rtl/cromPkg.sv
rtl/dbm.sv
rtl/dbus.sv
rtl/vmaRegister.sv
rtl/ramfile.sv
rtl/pcFlags.sv
rtl/dataBus.sv
dv/dataBusTb.sv

// File: Bender.yml
package:
  name: dataBus

sources:
  - rtl/ks10Pkg.sv
  - rtl/cromPkg.sv
  - rtl/dbm.sv
  - rtl/dbus.sv
  - rtl/vmaRegister.sv
  - rtl/ramfile.sv
  - rtl/pcFlags.sv
  - rtl/dataBus.sv
  - target: test
    files:
      - dv/dataBusTb.sv
